/* logic/m68k_bus_pkg.sv */
//////////////////////////////////////////////////
// 68000 bus control constants
// E clock division, pin filter indices and
// bus arbiter state codes
//////////////////////////////////////////////////

package m68k_bus_pkg;

	//////////////////////////////////////////////////
	// E clock
	//////////////////////////////////////////////////
	localparam int E_DIV   = 10;	// cpu clocks per E period
	localparam int E_HIGH  = 4;	// cpu clocks E is high
	localparam int E_CNT_W = 4;	// phase counter width

	//////////////////////////////////////////////////
	// Conditioned pins
	//////////////////////////////////////////////////
	localparam int NUM_PINS  = 5;
	localparam int PIN_IPL0  = 0;
	localparam int PIN_IPL1  = 1;
	localparam int PIN_IPL2  = 2;
	localparam int PIN_BR    = 3;
	localparam int PIN_BGACK = 4;

	// Interrupt level
	localparam int IPL_W     = 3;
	localparam int NMI_LEVEL = 7;	// Not maskable

	//////////////////////////////////////////////////
	// Arbiter states
	//////////////////////////////////////////////////
	localparam logic [1:0] ARB_IDLE  = 2'd0;
	localparam logic [1:0] ARB_GRANT = 2'd1;	// BG driven low
	localparam logic [1:0] ARB_OWNED = 2'd2;	// External master holds bus

endpackage

/* logic/phase_e_clock.sv */
//////////////////////////////////////////////////
// Processor clock phase generator
// Finds cpu_clk edges in the MCLK domain, issues
// sample and update strobes, and divides the
// falling edges down to the E clock
//////////////////////////////////////////////////

`timescale 1ns/1ps

module phase_e_clock import m68k_bus_pkg::*;
(
	input  logic MCLK,
	input  logic rst_n,
	input  logic cpu_clk,
	output logic sample,
	output logic update,
	output logic e_clk
);

	logic               clk_q1;		// First look at cpu_clk
	logic               clk_q2;		// Previous level
	logic               clk_fall;
	logic               clk_rise;
	logic [E_CNT_W-1:0] phase;
	logic [E_CNT_W-1:0] phase_next;

	//////////////////////////////////////////////////
	// Edge detection
	//////////////////////////////////////////////////
	always_ff @(posedge MCLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			clk_q1 <= 1'b0;
			clk_q2 <= 1'b0;
		end
		else
		begin
			clk_q1 <= cpu_clk;
			clk_q2 <= clk_q1;
		end
	end

	assign clk_fall = clk_q2 & ~clk_q1;
	assign clk_rise = ~clk_q2 & clk_q1;

	//////////////////////////////////////////////////
	// E clock divider
	//////////////////////////////////////////////////
	always_comb
	begin
		if (phase == E_CNT_W'(E_DIV - 1))
			phase_next = '0;	// Wrap at end of period
		else
			phase_next = phase + 1'b1;
	end

	// E goes high after phase 5 and low after phase 9
	always_ff @(posedge MCLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sample <= 1'b0;
			update <= 1'b0;
			phase  <= '0;
			e_clk  <= 1'b0;
		end
		else
		begin
			sample <= clk_fall;
			update <= clk_rise;
			if (clk_fall)
			begin
				phase <= phase_next;
				e_clk <= (phase_next >= E_CNT_W'(E_DIV - E_HIGH));
			end
		end
	end

endmodule

/* logic/pin_filter.sv */
//////////////////////////////////////////////////
// Asynchronous pin conditioner
// Two-flop synchronizer plus a two-sample
// agreement filter on an active-low pin
//////////////////////////////////////////////////

`timescale 1ns/1ps

module pin_filter
(
	input  logic MCLK,
	input  logic rst_n,
	input  logic sample,
	input  logic pin_n,
	output logic asserted
);

	logic meta_n;	// First synchronizer stage
	logic sync_n;
	logic last_n;	// Value seen at previous sample

	always_ff @(posedge MCLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			meta_n <= 1'b1;
			sync_n <= 1'b1;
		end
		else
		begin
			meta_n <= pin_n;
			sync_n <= meta_n;
		end
	end

	// A single odd sample never reaches asserted
	always_ff @(posedge MCLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			last_n   <= 1'b1;
			asserted <= 1'b0;
		end
		else if (sample)
		begin
			last_n <= sync_n;
			if (sync_n == last_n)
				asserted <= ~sync_n;	// Two in a row agree
		end
	end

endmodule

/* logic/bus_arbiter.sv */
//////////////////////////////////////////////////
// Bus arbiter
// Three-state grant machine stepping on update,
// drives BG from conditioned BR and BGACK
//////////////////////////////////////////////////

`timescale 1ns/1ps

module bus_arbiter import m68k_bus_pkg::*;
(
	input  logic MCLK,
	input  logic rst_n,
	input  logic update,
	input  logic br,
	input  logic bgack,
	output logic bg_n
);

	logic [1:0] state;
	logic [1:0] state_next;

	//////////////////////////////////////////////////
	// Next state
	//////////////////////////////////////////////////
	always_comb
	begin
		state_next = state;
		case (state)
			ARB_IDLE:
			begin
				if (bgack)
					state_next = ARB_OWNED;	// Master took bus unasked
				else if (br)
					state_next = ARB_GRANT;
			end
			ARB_GRANT:
			begin
				if (bgack)
					state_next = ARB_OWNED;
				else if (!br)
					state_next = ARB_IDLE;	// Request withdrawn
			end
			ARB_OWNED:
			begin
				if (!bgack)
				begin
					if (br)
						state_next = ARB_GRANT;
					else
						state_next = ARB_IDLE;
				end
			end
			default:
				state_next = ARB_IDLE;
		endcase
	end

	//////////////////////////////////////////////////
	// State and grant output
	//////////////////////////////////////////////////
	always_ff @(posedge MCLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= ARB_IDLE;
			bg_n  <= 1'b1;
		end
		else if (update)
		begin
			state <= state_next;
			bg_n  <= (state_next != ARB_GRANT);	// Low only while granting
		end
	end

endmodule

/* logic/int_priority.sv */
//////////////////////////////////////////////////
// Interrupt priority comparator
// Latches the conditioned IPL level and flags a
// pending request above the mask or at level 7
//////////////////////////////////////////////////

`timescale 1ns/1ps

module int_priority import m68k_bus_pkg::*;
(
	input  logic             MCLK,
	input  logic             rst_n,
	input  logic             update,
	input  logic [IPL_W-1:0] ipl,
	input  logic [IPL_W-1:0] int_mask,
	output logic [IPL_W-1:0] int_level,
	output logic             int_pending
);

	logic above_mask;
	logic is_nmi;

	assign above_mask = (ipl > int_mask);
	assign is_nmi     = (ipl == IPL_W'(NMI_LEVEL));	// Ignores mask

	always_ff @(posedge MCLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			int_level   <= '0;
			int_pending <= 1'b0;
		end
		else if (update)
		begin
			int_level   <= ipl;
			int_pending <= above_mask | is_nmi;
		end
	end

endmodule

/* logic/m68k_bus_ctrl.sv */
//////////////////////////////////////////////////
// 68000 pin-side bus control, top level
// Phase and E clock generation, pin conditioning,
// bus arbitration and interrupt compare
//////////////////////////////////////////////////

`timescale 1ns/1ps

module m68k_bus_ctrl import m68k_bus_pkg::*;
(
	input  logic             MCLK,
	input  logic             rst_n,
	input  logic             cpu_clk,
	input  logic             br_n,
	input  logic             bgack_n,
	input  logic [IPL_W-1:0] ipl_n,
	input  logic [IPL_W-1:0] int_mask,
	output logic             e_clk,
	output logic             bg_n,
	output logic [IPL_W-1:0] int_level,
	output logic             int_pending
);

	logic                sample;
	logic                update;
	logic [NUM_PINS-1:0] pin_raw_n;	// Raw pins in filter order
	logic [NUM_PINS-1:0] pin_level;	// Conditioned, active high
	logic [IPL_W-1:0]    ipl_level;

	//////////////////////////////////////////////////
	// Clock phases
	//////////////////////////////////////////////////
	phase_e_clock u_phase_e_clock
	(
		.MCLK    (MCLK),
		.rst_n   (rst_n),
		.cpu_clk (cpu_clk),
		.sample  (sample),
		.update  (update),
		.e_clk   (e_clk)
	);

	//////////////////////////////////////////////////
	// Pin conditioning
	//////////////////////////////////////////////////
	assign pin_raw_n[PIN_IPL0]  = ipl_n[0];
	assign pin_raw_n[PIN_IPL1]  = ipl_n[1];
	assign pin_raw_n[PIN_IPL2]  = ipl_n[2];
	assign pin_raw_n[PIN_BR]    = br_n;
	assign pin_raw_n[PIN_BGACK] = bgack_n;

	for (genvar i = 0; i < NUM_PINS; i++)
	begin : g_pin
		pin_filter u_pin_filter
		(
			.MCLK     (MCLK),
			.rst_n    (rst_n),
			.sample   (sample),
			.pin_n    (pin_raw_n[i]),
			.asserted (pin_level[i])
		);
	end

	//////////////////////////////////////////////////
	// Arbitration and interrupts
	//////////////////////////////////////////////////
	bus_arbiter u_bus_arbiter
	(
		.MCLK   (MCLK),
		.rst_n  (rst_n),
		.update (update),
		.br     (pin_level[PIN_BR]),
		.bgack  (pin_level[PIN_BGACK]),
		.bg_n   (bg_n)
	);

	assign ipl_level = {pin_level[PIN_IPL2], pin_level[PIN_IPL1], pin_level[PIN_IPL0]};

	int_priority u_int_priority
	(
		.MCLK        (MCLK),
		.rst_n       (rst_n),
		.update      (update),
		.ipl         (ipl_level),
		.int_mask    (int_mask),
		.int_level   (int_level),
		.int_pending (int_pending)
	);

endmodule

/* verification/m68k_bus_checker.sv */
//////////////////////////////////////////////////
// Bus control assertions, bound to the top level
//////////////////////////////////////////////////

`timescale 1ns/1ps

module m68k_bus_checker import m68k_bus_pkg::*;
(
	input  logic             MCLK,
	input  logic             rst_n,
	input  logic             e_clk,
	input  logic [IPL_W-1:0] int_level,
	input  logic             int_pending
);

	localparam int CPU_MCLK = 8;	// MCLK cycles per cpu clock

	int high_cnt;
	int level_fails = 0;
	int reset_fails = 0;
	int e_fails     = 0;
	int assert_fails;

	assign assert_fails = level_fails + reset_fails + e_fails;

	always_ff @(posedge MCLK or negedge rst_n)
	begin
		if (!rst_n)
			high_cnt <= 0;
		else if (e_clk)
			high_cnt <= high_cnt + 1;
		else
			high_cnt <= 0;
	end

	a_pend_level: assert property (@(posedge MCLK) disable iff (!rst_n)
		int_pending |-> (int_level != '0))
		else
		begin
			level_fails++;
			$error("int_pending set with int_level zero");
		end

	a_pend_reset: assert property (@(posedge MCLK) !rst_n |-> !$rose(int_pending))
		else
		begin
			reset_fails++;
			$error("int_pending rose during reset");
		end

	a_e_high: assert property (@(posedge MCLK) disable iff (!rst_n)
		high_cnt <= E_HIGH * CPU_MCLK)
		else
		begin
			e_fails++;
			$error("e_clk high longer than E_HIGH cpu clocks");
		end

endmodule

/* verification/m68k_bus_monitor.sv */
//////////////////////////////////////////////////
// Bus control monitor
// Compares DUT outputs with expected values on
// request and measures the E clock
//////////////////////////////////////////////////

`timescale 1ns/1ps

module m68k_bus_monitor
(
	input  logic       MCLK,
	input  logic       e_clk,
	input  logic       bg_n,
	input  logic [2:0] int_level,
	input  logic       int_pending,
	input  logic       check_req,
	input  logic       check_e,
	input  logic       hold_chk,
	input  logic       exp_bg_n,
	input  logic [2:0] exp_level,
	input  logic       exp_pending,
	input  logic       measure_req,
	output logic       measure_done,
	output int         err_count,
	output int         test_count
);

	localparam int E_PERIOD_CYC = 80;	// Ten cpu clocks
	localparam int E_HIGH_CYC   = 32;

	int cycle     = 0;
	int chk_errs  = 0;
	int chk_tests = 0;
	int hold_errs = 0;
	int e_errs    = 0;
	int e_tests   = 0;

	initial
		measure_done = 1'b0;

	assign err_count  = chk_errs + e_errs;
	assign test_count = chk_tests + e_tests;

	always @(posedge MCLK)
		cycle <= cycle + 1;

	task automatic wait_e(input logic level);
		do
			@(negedge MCLK);	// Outputs are stable mid-cycle
		while (e_clk !== level);
	endtask

	//////////////////////////////////////////////////
	// Level held steady across a glitch
	//////////////////////////////////////////////////
	always @(negedge MCLK)
	begin
		if (hold_chk === 1'b1 && hold_errs == 0 && int_level !== exp_level)
		begin
			$display("error at %0t: int_level is %0d, expected %0d while glitch held", $time,
				int_level, exp_level);
			hold_errs++;
		end
	end

	//////////////////////////////////////////////////
	// Output compare
	//////////////////////////////////////////////////
	always @(posedge check_req)
	begin : compare_outputs
		int bad;
		bad = 0;
		if (bg_n !== exp_bg_n)
		begin
			$display("error at %0t: bg_n is %b, expected %b", $time, bg_n, exp_bg_n);
			bad++;
		end
		if (int_level !== exp_level)
		begin
			$display("error at %0t: int_level is %0d, expected %0d", $time, int_level, exp_level);
			bad++;
		end
		if (int_pending !== exp_pending)
		begin
			$display("error at %0t: int_pending is %b, expected %b", $time, int_pending,
				exp_pending);
			bad++;
		end
		if (check_e && e_clk !== 1'b0)
		begin
			$display("error at %0t: e_clk is %b, expected 0", $time, e_clk);
			bad++;
		end
		bad += hold_errs;
		hold_errs = 0;
		chk_tests++;
		chk_errs += bad;
		$display("check %0d: %s", chk_tests, (bad == 0) ? "ok" : "mismatch");
	end

	//////////////////////////////////////////////////
	// E clock over three periods
	//////////////////////////////////////////////////
	always @(posedge measure_req)
	begin : measure_e
		int rise_t;
		int high_t;
		int period_t;
		int bad;
		bad = 0;
		wait_e(1'b0);
		wait_e(1'b1);
		rise_t = cycle;
		for (int k = 0; k < 3; k++)
		begin
			wait_e(1'b0);
			high_t = cycle - rise_t;
			wait_e(1'b1);
			period_t = cycle - rise_t;
			rise_t = cycle;
			if (high_t != E_HIGH_CYC)
			begin
				$display("error at %0t: e_clk high time is %0d, expected %0d", $time, high_t,
					E_HIGH_CYC);
				bad++;
			end
			if (period_t != E_PERIOD_CYC)
			begin
				$display("error at %0t: e_clk period is %0d, expected %0d", $time, period_t,
					E_PERIOD_CYC);
				bad++;
			end
		end
		e_errs  = bad;
		e_tests = 1;
		$display("E clock measurement: %s", (bad == 0) ? "ok" : "mismatch");
		measure_done = 1'b1;
	end

endmodule

/* verification/m68k_bus_tb.sv */
//////////////////////////////////////////////////
// Testbench for the 68000 bus control top level
// Applies pin patterns from a data file and hands
// the expected outputs to the monitor
//////////////////////////////////////////////////

`timescale 1ns/1ps

module m68k_bus_tb;

	localparam int MCLK_PERIOD = 100;
	localparam int CPU_HALF    = 4;			// MCLK cycles per cpu_clk half
	localparam int SETTLE      = 16 * CPU_HALF;	// Eight cpu clocks
	localparam int PAT_COUNT   = 19;
	localparam int E_MEAS      = 80 * CPU_HALF;	// Four E periods
	localparam int LIMIT       = PAT_COUNT * (SETTLE + 4 * CPU_HALF) + E_MEAS + 200;

	logic        MCLK;
	logic        rst_n;
	logic        cpu_clk;
	logic        br_n;
	logic        bgack_n;
	logic [2:0]  ipl_n;
	logic [2:0]  int_mask;
	logic        e_clk;
	logic        bg_n;
	logic [2:0]  int_level;
	logic        int_pending;
	logic        check_req;
	logic        check_e;
	logic        hold_chk;
	logic        exp_bg_n;
	logic [2:0]  exp_level;
	logic        exp_pending;
	logic        measure_req;
	logic        measure_done;
	int          err_count;
	int          test_count;
	int          fails;
	logic [31:0] pat [PAT_COUNT];
	logic [2:0]  prev_ipl_n;

	m68k_bus_ctrl u_dut
	(
		.MCLK        (MCLK),
		.rst_n       (rst_n),
		.cpu_clk     (cpu_clk),
		.br_n        (br_n),
		.bgack_n     (bgack_n),
		.ipl_n       (ipl_n),
		.int_mask    (int_mask),
		.e_clk       (e_clk),
		.bg_n        (bg_n),
		.int_level   (int_level),
		.int_pending (int_pending)
	);

	m68k_bus_monitor u_monitor
	(
		.MCLK         (MCLK),
		.e_clk        (e_clk),
		.bg_n         (bg_n),
		.int_level    (int_level),
		.int_pending  (int_pending),
		.check_req    (check_req),
		.check_e      (check_e),
		.hold_chk     (hold_chk),
		.exp_bg_n     (exp_bg_n),
		.exp_level    (exp_level),
		.exp_pending  (exp_pending),
		.measure_req  (measure_req),
		.measure_done (measure_done),
		.err_count    (err_count),
		.test_count   (test_count)
	);

	//////////////////////////////////////////////////
	// Clocks and watchdog
	//////////////////////////////////////////////////
	initial
	begin
		MCLK = 1'b0;
		forever #(MCLK_PERIOD / 2) MCLK = ~MCLK;
	end

	initial
	begin
		cpu_clk = 1'b0;
		forever
		begin
			repeat (CPU_HALF) @(posedge MCLK);
			#1 cpu_clk = ~cpu_clk;
		end
	end

	initial
	begin
		#(LIMIT * MCLK_PERIOD);
		$display("Watchdog expired before all tests finished");
		$display("Regression failed");
		$finish;
	end

	task automatic run_check(input logic bg, input logic [2:0] lvl, input logic pend,
		input logic e_low);
		@(posedge MCLK);
		#1;
		exp_bg_n    = bg;
		exp_level   = lvl;
		exp_pending = pend;
		check_e     = e_low;
		hold_chk    = 1'b0;
		check_req   = 1'b1;
		@(posedge MCLK);
		#1 check_req = 1'b0;
	endtask

	task automatic measure_e_clock;
		@(posedge MCLK);
		#1 measure_req = 1'b1;
		wait (measure_done);
		#1 measure_req = 1'b0;
	endtask

	// Glitch lines hold ipl_n for one cpu clock only
	task automatic apply_line(input logic [31:0] word);
		@(posedge MCLK);
		#1;
		br_n     = word[28];
		bgack_n  = word[24];
		int_mask = word[18:16];
		ipl_n    = word[22:20];
		if (word[0])
		begin
			exp_bg_n    = word[12];
			exp_level   = word[10:8];
			exp_pending = word[4];
			hold_chk    = 1'b1;	// int_level must not move
			repeat (2 * CPU_HALF) @(posedge MCLK);
			#1 ipl_n = prev_ipl_n;
		end
		else
			prev_ipl_n = word[22:20];
		repeat (SETTLE) @(posedge MCLK);
		run_check(word[12], word[10:8], word[4], 1'b0);
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////
	initial
	begin
		rst_n       = 1'b0;
		br_n        = 1'b1;
		bgack_n     = 1'b1;
		ipl_n       = 3'b111;
		int_mask    = 3'b000;
		check_req   = 1'b0;
		check_e     = 1'b0;
		hold_chk    = 1'b0;
		exp_bg_n    = 1'b1;
		exp_level   = 3'd0;
		exp_pending = 1'b0;
		measure_req = 1'b0;
		prev_ipl_n  = 3'b111;
		$readmemh("verification/m68k_bus_patterns.txt", pat);
		repeat (10) @(posedge MCLK);
		#1 rst_n = 1'b1;
		run_check(1'b1, 3'd0, 1'b0, 1'b1);	// Reset values
		measure_e_clock;
		for (int i = 0; i < PAT_COUNT; i++)
			apply_line(pat[i]);
		repeat (2) @(posedge MCLK);
		fails = u_dut.u_checker.assert_fails;
		$display("%0d tests, %0d errors, %0d assertion failures", test_count, err_count, fails);
		if (err_count == 0 && fails == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

bind m68k_bus_ctrl m68k_bus_checker u_checker
(
	.MCLK        (MCLK),
	.rst_n       (rst_n),
	.e_clk       (e_clk),
	.int_level   (int_level),
	.int_pending (int_pending)
);

/* verification/m68k_bus_patterns.txt */
// br_n bgack_n ipl_n int_mask | expected bg_n int_level int_pending | glitch
// One hex digit per column, glitch lines expect the previous outputs
1_1_7_0_1_0_0_0
0_1_7_0_0_0_0_0
0_0_7_0_1_0_0_0
0_1_7_0_0_0_0_0
1_1_7_0_1_0_0_0
1_1_6_0_1_1_1_0
1_1_6_1_1_1_0_0
1_1_5_1_1_2_1_0
1_1_4_3_1_3_0_0
1_1_3_3_1_4_1_0
1_1_2_6_1_5_0_0
1_1_1_5_1_6_1_0
1_1_1_6_1_6_0_0
1_1_0_7_1_7_1_0
1_1_7_0_1_0_0_0
1_1_2_0_1_0_0_1
1_1_4_2_1_3_1_0
1_1_7_2_1_3_1_1
1_1_7_7_1_0_0_0

/* files.f */
logic/m68k_bus_pkg.sv
logic/phase_e_clock.sv
logic/pin_filter.sv
logic/bus_arbiter.sv
logic/int_priority.sv
logic/m68k_bus_ctrl.sv
verification/m68k_bus_checker.sv
verification/m68k_bus_monitor.sv
verification/m68k_bus_tb.sv

/* Makefile */
# Verilator build and regression for the 68000 bus control

VERILATOR ?= verilator
TOP       ?= m68k_bus_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= Regression failed
PASS_MSG  ?= Regression passed

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
